// File: Makefile
SIM := obj_dir/Vpool_tb

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): filelist.f $(wildcard source/*.sv source/*.svh) verif/pool_tb.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module pool_tb -f filelist.f

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// File: filelist.f
+incdir+source
source/pool_data_pkg.sv
source/pool_ctrl_pkg.sv
source/pool_stage_if.sv
source/pool_col_ctrl.sv
source/max_pool_core.sv
source/pool_out_stage.sv
source/pool_layer_top.sv
verif/pool_tb.sv

// File: source/max_pool_core.sv
`timescale 1ns/1ps
`include "pool_cfg.svh"

module max_pool_core (
    input  logic                     clk,
    input  logic                     rst_n,
    pool_stage_if.core               stage,
    output pool_data_pkg::pool_vec_t pool_data,
    output logic                     pool_valid,
    output logic                     pool_last
);

    localparam int PAIRS = `POOL_LANES / 2;
    localparam int PW    = `POOL_PIX_W;

    function automatic pool_data_pkg::pix_t max_pix(
        input pool_data_pkg::pix_t a,
        input pool_data_pkg::pix_t b
    );
        return (a > b) ? a : b;
    endfunction

    pool_data_pkg::pool_vec_t vert_next;
    pool_data_pkg::pool_vec_t vert_max;     // stage one result
    pool_data_pkg::pool_vec_t held_vec;     // first column of a pair
    pool_data_pkg::pool_vec_t horiz;
    logic v_valid;
    logic v_pair;
    logic v_last;
    logic v_active;
    logic held;                             // held_vec is waiting for its partner

    always_comb
    begin
        for (int i = 0; i < PAIRS; i++)
        begin
            vert_next[i*PW +: PW] = max_pix(stage.col_data[2*i*PW +: PW],
                                            stage.col_data[(2*i+1)*PW +: PW]);
            horiz[i*PW +: PW] = max_pix(held_vec[i*PW +: PW], vert_max[i*PW +: PW]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            v_valid    <= 1'b0;
            v_pair     <= 1'b0;
            v_last     <= 1'b0;
            v_active   <= 1'b0;
            held       <= 1'b0;
            pool_valid <= 1'b0;
            pool_last  <= 1'b0;
        end
        else
        begin
            v_valid    <= stage.col_valid;
            v_pair     <= stage.col_valid && stage.pair_done;
            v_last     <= stage.col_valid && stage.frame_last;
            v_active   <= stage.active;
            pool_valid <= v_valid && v_pair;
            pool_last  <= v_valid && v_last;
            if (v_valid)
            begin
                held <= !v_pair;
            end
            else if (!v_active)
            begin
                held <= 1'b0;   // drop any stale half pair between frames
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (stage.col_valid)
        begin
            vert_max <= vert_next;
        end
        if (v_valid && !v_pair)
        begin
            held_vec <= vert_max;
        end
        if (v_valid && v_pair)
        begin
            pool_data <= held ? horiz : vert_max;   // lone odd column passes alone
        end
    end

    // the frame's last result always closes a pair
    a_last_valid: assert property (
        @(posedge clk) disable iff (!rst_n)
        pool_last |-> pool_valid
    ) else $error("pool_last without pool_valid");

endmodule

// File: source/pool_cfg.svh
`ifndef POOL_CFG_SVH
`define POOL_CFG_SVH

// pixels per input column
`define POOL_LANES 24

// bits per pixel
`define POOL_PIX_W 8

// column counter, wide enough for any col value
`define POOL_COL_W 16

`endif

// File: source/pool_col_ctrl.sv
`timescale 1ns/1ps

module pool_col_ctrl (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pool_en,
    input  logic                    valid_in,
    input  pool_data_pkg::col_vec_t data_in,
    input  pool_data_pkg::col_cnt_t col,
    pool_stage_if.ctrl              stage
);

    pool_ctrl_pkg::ctrl_state_t state;
    pool_data_pkg::col_cnt_t    cnt;        // index of the next accepted column
    logic                       valid_d;
    logic                       start;
    logic                       accept;
    logic                       last;

    // a frame only starts on a rising valid_in, so columns past col
    // are dropped until valid_in has gone low again
    assign start  = pool_en && valid_in && !valid_d && (state == pool_ctrl_pkg::IDLE);
    assign accept = start || ((state == pool_ctrl_pkg::RUN) && valid_in);
    assign last   = (cnt == col - pool_data_pkg::col_cnt_t'(1));

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            state            <= pool_ctrl_pkg::IDLE;
            cnt              <= '0;
            valid_d          <= 1'b0;
            stage.col_valid  <= 1'b0;
            stage.pair_done  <= 1'b0;
            stage.frame_last <= 1'b0;
            stage.active     <= 1'b0;
        end
        else
        begin
            valid_d          <= valid_in;
            stage.col_valid  <= accept;
            stage.pair_done  <= accept && (cnt[0] || last);   // odd index or lone tail
            stage.frame_last <= accept && last;
            stage.active     <= accept || (state == pool_ctrl_pkg::RUN);
            if (accept)
            begin
                if (last)
                begin
                    cnt   <= '0;
                    state <= pool_ctrl_pkg::IDLE;
                end
                else
                begin
                    cnt   <= cnt + pool_data_pkg::col_cnt_t'(1);
                    state <= pool_ctrl_pkg::RUN;
                end
            end
        end
    end

    // column payload
    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            stage.col_data <= data_in;
        end
    end

    // a zero column count would never reach frame_last
    a_col_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n)
        start |-> (col != '0)
    ) else $error("pool frame started with col == 0");

endmodule

// File: source/pool_ctrl_pkg.sv
package pool_ctrl_pkg;

    // column control FSM
    typedef enum logic {
        IDLE,   // waiting for a frame to start
        RUN     // columns of a pooling frame arriving
    } ctrl_state_t;

endpackage

// File: source/pool_data_pkg.sv
`include "pool_cfg.svh"

package pool_data_pkg;

    // single feature-map pixel
    typedef logic [`POOL_PIX_W-1:0] pix_t;

    typedef logic [`POOL_LANES*`POOL_PIX_W-1:0] col_vec_t;       // full input column

    // result after row-pair reduction, half the lanes
    typedef logic [(`POOL_LANES/2)*`POOL_PIX_W-1:0] pool_vec_t;

    typedef logic [`POOL_COL_W-1:0] col_cnt_t;                   // columns per frame

endpackage

// File: source/pool_layer_top.sv
`timescale 1ns/1ps

module pool_layer_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    pool_en,
    input  logic                    layer1,
    input  logic                    valid_in,
    input  pool_data_pkg::col_vec_t data_in,
    input  pool_data_pkg::col_cnt_t col,
    output pool_data_pkg::col_vec_t data_out,
    output logic                    valid_out,
    output logic                    pool_end
);

    pool_stage_if stage_if ();

    pool_data_pkg::pool_vec_t pool_data;
    logic pool_valid;
    logic pool_last;

    pool_col_ctrl pool_col_ctrl_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pool_en  (pool_en),
        .valid_in (valid_in),
        .data_in  (data_in),
        .col      (col),
        .stage    (stage_if.ctrl)
    );

    max_pool_core max_pool_core_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .stage      (stage_if.core),
        .pool_data  (pool_data),
        .pool_valid (pool_valid),
        .pool_last  (pool_last)
    );

    pool_out_stage pool_out_stage_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .pool_en    (pool_en),
        .layer1     (layer1),
        .valid_in   (valid_in),
        .data_in    (data_in),
        .pool_data  (pool_data),
        .pool_valid (pool_valid),
        .pool_last  (pool_last),
        .data_out   (data_out),
        .valid_out  (valid_out),
        .pool_end   (pool_end)
    );

endmodule

// File: source/pool_out_stage.sv
`timescale 1ns/1ps
`include "pool_cfg.svh"

module pool_out_stage (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     pool_en,
    input  logic                     layer1,
    input  logic                     valid_in,
    input  pool_data_pkg::col_vec_t  data_in,
    input  pool_data_pkg::pool_vec_t pool_data,
    input  logic                     pool_valid,
    input  logic                     pool_last,
    output pool_data_pkg::col_vec_t  data_out,
    output logic                     valid_out,
    output logic                     pool_end
);

    localparam int PW     = `POOL_PIX_W;
    localparam int COL_W  = `POOL_LANES * PW;
    localparam int POOL_W = (`POOL_LANES / 2) * PW;
    localparam int KEEP_W = (`POOL_LANES / 4) * PW;    // lanes 0..5 for the 12-row case

    pool_data_pkg::pool_vec_t pool_masked;
    logic valid_d;
    logic bypass_end;

    always_comb
    begin
        pool_masked = pool_data;
        if (!layer1)
        begin
            pool_masked[POOL_W-1:KEEP_W] = '0;
        end
    end

    assign bypass_end = valid_d && !valid_in;   // first idle cycle after a frame

    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            valid_d   <= 1'b0;
            valid_out <= 1'b0;
            pool_end  <= 1'b0;
        end
        else
        begin
            valid_d   <= valid_in;
            valid_out <= pool_valid || (!pool_en && valid_in);
            pool_end  <= pool_last || (!pool_en && bypass_end);
        end
    end

    always_ff @(posedge clk)
    begin
        if (pool_en || pool_valid)
        begin
            data_out <= {{(COL_W-POOL_W){1'b0}}, pool_masked};
        end
        else
        begin
            data_out <= data_in;
        end
    end

    // pooled results only come out of a pooling frame
    a_no_pool_in_bypass: assert property (
        @(posedge clk) disable iff (!rst_n)
        pool_valid |-> pool_en
    ) else $error("pooled valid while pool_en is low");

    a_out_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown({valid_out, pool_end})
    ) else $error("valid_out or pool_end unknown after reset");

endmodule

// File: source/pool_stage_if.sv
`timescale 1ns/1ps

interface pool_stage_if;

    pool_data_pkg::col_vec_t col_data;  // registered column
    logic col_valid;                    // column accepted this cycle
    logic pair_done;                    // column closes a pair (or is the lone last one)
    logic frame_last;                   // last column of the frame
    logic active;                       // level, pooling frame in progress

    modport ctrl (
        output col_data,
        output col_valid,
        output pair_done,
        output frame_last,
        output active
    );

    modport core (
        input col_data,
        input col_valid,
        input pair_done,
        input frame_last,
        input active
    );

endinterface

// File: verif/pool_tb.sv
`timescale 1ns/1ps
`include "pool_cfg.svh"

module pool_tb;

    localparam int LANES       = `POOL_LANES;
    localparam int PW          = `POOL_PIX_W;
    localparam int N_FRAMES    = 80;
    localparam int DRAIN_LIMIT = 40;        // cycles allowed for a frame to drain

    logic                     clk;
    logic                     rst_n;
    logic                     pool_en;
    logic                     layer1;
    logic                     valid_in;
    pool_data_pkg::col_vec_t  data_in;
    pool_data_pkg::col_cnt_t  col;
    pool_data_pkg::col_vec_t  data_out;
    logic                     valid_out;
    logic                     pool_end;

    pool_data_pkg::col_vec_t  exp_q[$];     // expected outputs in arrival order
    pool_data_pkg::col_vec_t  exp_head;
    int out_cnt;                            // outputs seen in the current frame
    int exp_outs;
    int end_cnt;                            // pool_end pulses over the whole run
    logic last_valid;                       // valid_out at the previous sample

    pool_layer_top pool_layer_top_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pool_en   (pool_en),
        .layer1    (layer1),
        .valid_in  (valid_in),
        .data_in   (data_in),
        .col       (col),
        .data_out  (data_out),
        .valid_out (valid_out),
        .pool_end  (pool_end)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;     // inputs settle well away from the edge
    endtask

    function automatic pool_data_pkg::pix_t pix_at(input pool_data_pkg::col_vec_t c,
                                                   input int lane);
        return c[lane*PW +: PW];
    endfunction

    function automatic pool_data_pkg::col_vec_t random_column();
        pool_data_pkg::col_vec_t c;
        for (int l = 0; l < LANES; l++)
            c[l*PW +: PW] = pool_data_pkg::pix_t'($urandom);
        return c;
    endfunction

    // 2x2 max over rows 2m and 2m+1 of columns a and b
    // a lone last column is passed as both a and b
    function automatic pool_data_pkg::col_vec_t pool_ref(input pool_data_pkg::col_vec_t a,
                                                         input pool_data_pkg::col_vec_t b,
                                                         input logic full_depth);
        pool_data_pkg::col_vec_t r;
        pool_data_pkg::pix_t     best;
        r = '0;
        for (int m = 0; m < LANES/2; m++)
        begin
            best = '0;
            for (int k = 0; k < 2; k++)
            begin
                if (pix_at(a, 2*m+k) > best)
                    best = pix_at(a, 2*m+k);
                if (pix_at(b, 2*m+k) > best)
                    best = pix_at(b, 2*m+k);
            end
            if (full_depth || m < LANES/4)  // 12-row frame keeps lanes 0..5 only
                r[m*PW +: PW] = best;
        end
        return r;
    endfunction

    task automatic wait_frame_done(input int ends_before);
        int cycles;
        cycles = 0;
        while (!(end_cnt == ends_before + 1 && exp_q.size() == 0))
        begin
            if (cycles == DRAIN_LIMIT)
                report_failure("timeout: frame outputs or pool_end never arrived");
            next_cycle();
            cycles++;
        end
    endtask

    task automatic run_frame();
        pool_data_pkg::col_vec_t cols[$];
        int   ncol;
        int   extra;
        int   ends_before;
        logic mode_pool;
        logic deep;
        ncol      = $urandom_range(9, 1);
        mode_pool = ($urandom_range(3, 0) != 0);
        deep      = ($urandom_range(1, 0) == 1);
        extra     = mode_pool ? $urandom_range(2, 0) : 0;   // surplus columns the DUT ignores
        pool_en   = mode_pool;
        layer1    = deep;
        col       = pool_data_pkg::col_cnt_t'(ncol);
        next_cycle();

        for (int c = 0; c < ncol + extra; c++)
            cols.push_back(random_column());
        if (mode_pool)
        begin
            for (int c = 0; c < ncol; c += 2)
                exp_q.push_back(pool_ref(cols[c], (c + 1 < ncol) ? cols[c+1] : cols[c], deep));
            exp_outs = (ncol + 1) / 2;
        end
        else
        begin
            for (int c = 0; c < ncol; c++)
                exp_q.push_back(cols[c]);
            exp_outs = ncol;
        end
        out_cnt     = 0;
        ends_before = end_cnt;

        foreach (cols[c])
        begin
            valid_in = 1'b1;
            data_in  = cols[c];
            next_cycle();
        end
        valid_in = 1'b0;
        data_in  = random_column();     // idle data must not leak out

        wait_frame_done(ends_before);
        repeat ($urandom_range(5, 2)) next_cycle();
        assert (end_cnt == ends_before + 1)
            else report_failure($sformatf("error at %0t: pool_end count expected %0d, got %0d",
                                          $time, ends_before + 1, end_cnt));
    endtask

    // outputs sampled mid-cycle away from both edges
    always @(negedge clk)
    begin
        if (valid_out)
        begin
            assert (exp_q.size() > 0)
                else report_failure("valid_out went high with no output expected");
            exp_head = exp_q.pop_front();
            out_cnt++;
            assert (data_out === exp_head)
                else report_failure($sformatf("error at %0t: data_out expected %h, got %h",
                                              $time, exp_head, data_out));
        end
        if (pool_end)
        begin
            end_cnt++;
            assert (out_cnt == exp_outs)
                else report_failure($sformatf("error at %0t: output count expected %0d, got %0d",
                                              $time, exp_outs, out_cnt));
            if (pool_en)
            begin
                // pooled end sits on the last output
                assert (valid_out && exp_q.size() == 0)
                    else report_failure("pool_end did not come with the last output");
            end
            else
            begin
                // bypass end follows the last output directly
                assert (!valid_out && last_valid && exp_q.size() == 0)
                    else report_failure("pool_end did not follow the last output directly");
            end
        end
        last_valid = valid_out;
    end

    initial
    begin
        void'($urandom(32'hd5f4));
        rst_n      = 1'b0;
        pool_en    = 1'b0;
        layer1     = 1'b0;
        valid_in   = 1'b0;
        data_in    = '0;
        col        = '0;
        out_cnt    = 0;
        exp_outs   = 0;
        end_cnt    = 0;
        last_valid = 1'b0;
        repeat (8) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        assert (valid_out === 1'b0 && pool_end === 1'b0)
            else report_failure("valid_out or pool_end not low after reset");

        for (int f = 0; f < N_FRAMES; f++)
            run_frame();

        $display("Testbench passed");
        $finish;
    end

endmodule
